// ==== Bender.yml ====
package:
  name: se_stage

sources:
  - common/se_pkg.sv
  - design/se_control/se_step_counter.sv
  - design/se_control/se_sequencer.sv
  - design/se_datapath/avg_pool_accum.sv
  - design/se_datapath/se_weight_ram.sv
  - design/se_datapath/se_feature_buffer.sv
  - design/se_datapath/pe_array_1x1.sv
  - design/se_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/se_tb.sv

// ==== common/se_pkg.sv ====
`default_nettype none

package se_pkg;

    // frame and channel geometry
    localparam int num_ch      = 16;
    localparam int num_red     = 4;
    localparam int num_pe      = 4;
    localparam int pool_pixels = 16;

    // arithmetic shifts
    localparam int pool_shift  = 4;
    localparam int quant_shift = 8;

    // weight memory layout, reduce words first
    localparam int expand_base = 16;
    localparam int wram_depth  = 32;

    typedef logic [7:0]            byte_t;
    typedef logic [num_pe*8-1:0]   word_t;
    typedef logic [num_ch*8-1:0]   pixel_t;
    typedef logic [11:0]           pool_sum_t;
    typedef logic [23:0]           psum_t;
    typedef logic [3:0]            chan_idx_t;
    typedef logic [4:0]            waddr_t;
    typedef logic [1:0]            group_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } pixel_in_t;

    // data byte j holds the weight for lane j
    typedef struct packed {
        logic   en;
        waddr_t addr;
        word_t  data;
    } weight_wr_t;

    typedef struct packed {
        group_t group;
        word_t  data;
    } se_result_t;

    typedef enum logic [1:0] {
        ST_POOL,
        ST_REDUCE,
        ST_EXPAND,
        ST_SEND
    } se_state_t;

endpackage

`default_nettype wire

// ==== design/se_control/se_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module se_sequencer import se_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      frame_done,
    input  wire chan_idx_t k,
    input  wire group_t    g,
    input  wire logic      last_k,
    input  wire logic      last_g,
    input  wire word_t     pe_result,
    input  wire logic      res_ack,
    output se_state_t      state,
    output logic           step,
    output logic           clear,
    output logic           limit_small,
    output chan_idx_t      fb_rd_idx,
    output logic           fb_rd_red,
    output waddr_t         wr_rd_addr,
    output logic           pe_clear,
    output logic           pe_acc_en,
    output logic           fb_red_we,
    output se_result_t     res,
    output logic           res_req
);

    logic       draining;
    logic [1:0] drain_cnt;
    logic       acc_req;
    logic       acc_req_q;
    logic       drain_done;
    logic       send_done;

    // one read request per channel until the last index is issued
    assign acc_req = (state == ST_REDUCE || state == ST_EXPAND) && !draining;

    // reduce needs an extra cycle to write the squeezed bytes
    assign drain_done = draining && (drain_cnt == ((state == ST_REDUCE) ? 2'd2 : 2'd1));

    // handshake closed once req dropped and ack seen low
    assign send_done = (state == ST_SEND) && !res_req && !res_ack;

    // hold k on the last index, wrap it after the send instead
    assign step        = (acc_req && !last_k) || (send_done && !last_g);
    assign clear       = (state == ST_POOL) || fb_red_we;
    assign limit_small = (state == ST_EXPAND) || (state == ST_SEND);

    assign fb_red_we = (state == ST_REDUCE) && drain_done;
    assign pe_clear  = (state == ST_POOL) || (state == ST_SEND) || fb_red_we;
    assign pe_acc_en = acc_req_q;

    assign fb_rd_idx = k;
    assign fb_rd_red = (state == ST_EXPAND);

    // expand word for output group g and squeezed channel k
    assign wr_rd_addr = (state == ST_EXPAND) ?
                        waddr_t'(expand_base) + waddr_t'({g, k[1:0]}) :
                        waddr_t'(k);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_POOL;
            draining  <= 1'b0;
            drain_cnt <= '0;
            acc_req_q <= 1'b0;
            res_req   <= 1'b0;
        end else begin
            // data comes back one cycle after the address
            acc_req_q <= acc_req;
            case (state)
                ST_POOL: begin
                    if (frame_done) begin
                        state <= ST_REDUCE;
                    end
                end
                ST_REDUCE, ST_EXPAND: begin
                    if (!draining) begin
                        drain_cnt <= '0;
                        draining  <= last_k;
                    end else if (drain_done) begin
                        draining <= 1'b0;
                        if (state == ST_REDUCE) begin
                            state <= ST_EXPAND;
                        end else begin
                            state   <= ST_SEND;
                            res_req <= 1'b1;
                        end
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                ST_SEND: begin
                    if (res_req && res_ack) begin
                        res_req <= 1'b0;
                    end else if (send_done) begin
                        state <= last_g ? ST_POOL : ST_EXPAND;
                    end
                end
                default: state <= ST_POOL;
            endcase
        end
    end

    // result held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (state == ST_EXPAND && drain_done) begin
            res.group <= g;
            res.data  <= pe_result;
        end
    end

endmodule

`default_nettype wire

// ==== design/se_control/se_step_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module se_step_counter import se_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic step,
    input  wire logic clear,
    input  wire logic limit_small,
    output chan_idx_t k,
    output group_t    g,
    output logic      last_k,
    output logic      last_g
);

    // 16 input channels for reduce, 4 squeezed channels for expand
    assign last_k = limit_small ? (k == chan_idx_t'(num_red - 1)) :
                                  (k == chan_idx_t'(num_ch - 1));

    // one expand pass per group of lanes
    assign last_g = (g == group_t'(num_ch / num_pe - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k <= '0;
            g <= '0;
        end else if (clear) begin
            k <= '0;
            g <= '0;
        end else if (step) begin
            if (last_k) begin
                k <= '0;
                g <= g + group_t'(1);
            end else begin
                k <= k + chan_idx_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/se_datapath/avg_pool_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

module avg_pool_accum import se_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire pixel_in_t pixel_in,
    input  wire logic      accept,
    output pixel_t         avg,
    output logic           frame_done
);

    pool_sum_t  sum_q   [num_ch];
    pool_sum_t  sum_nxt [num_ch];
    logic [3:0] pix_cnt;
    logic       take;
    logic       last_pix;

    assign take     = pixel_in.valid && accept;
    assign last_pix = (pix_cnt == 4'(pool_pixels - 1));

    // running sum including the current pixel
    always_comb begin
        for (int c = 0; c < num_ch; c++) begin
            sum_nxt[c] = sum_q[c] + pool_sum_t'(pixel_in.data[c*8 +: 8]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt    <= '0;
            frame_done <= 1'b0;
            for (int c = 0; c < num_ch; c++) begin
                sum_q[c] <= '0;
            end
        end else begin
            frame_done <= take && last_pix;
            if (take) begin
                pix_cnt <= last_pix ? 4'd0 : pix_cnt + 4'd1;
                // last pixel starts the next frame from zero
                for (int c = 0; c < num_ch; c++) begin
                    sum_q[c] <= last_pix ? pool_sum_t'(0) : sum_nxt[c];
                end
            end
        end
    end

    // truncating average, valid while frame_done is high
    always_ff @(posedge clk) begin
        if (take && last_pix) begin
            for (int c = 0; c < num_ch; c++) begin
                avg[c*8 +: 8] <= byte_t'(sum_nxt[c] >> pool_shift);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/se_datapath/pe_array_1x1.sv ====
`timescale 1ns/1ns
`default_nettype none

module pe_array_1x1 import se_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  clear,
    input  wire logic  acc_en,
    input  wire byte_t act,
    input  wire word_t weights,
    output word_t      result
);

    psum_t       acc     [num_pe];
    psum_t       shifted [num_pe];
    logic [15:0] prod    [num_pe];

    // same activation broadcast to every lane
    always_comb begin
        for (int j = 0; j < num_pe; j++) begin
            prod[j] = act * weights[j*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < num_pe; j++) begin
                acc[j] <= '0;
            end
        end else if (clear) begin
            for (int j = 0; j < num_pe; j++) begin
                acc[j] <= '0;
            end
        end else if (acc_en) begin
            for (int j = 0; j < num_pe; j++) begin
                acc[j] <= acc[j] + psum_t'(prod[j]);
            end
        end
    end

    // requantize, clip anything above one byte
    always_comb begin
        for (int j = 0; j < num_pe; j++) begin
            shifted[j] = acc[j] >> quant_shift;
            if (shifted[j] > psum_t'(255)) begin
                result[j*8 +: 8] = 8'hff;
            end else begin
                result[j*8 +: 8] = shifted[j][7:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/se_datapath/se_feature_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module se_feature_buffer import se_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      avg_we,
    input  wire pixel_t    avg,
    input  wire logic      red_we,
    input  wire word_t     red,
    input  wire chan_idx_t rd_idx,
    input  wire logic      rd_red,
    output byte_t          rd_byte
);

    byte_t avg_mem [num_ch];
    byte_t red_mem [num_red];

    // whole frame of averages or all squeezed lanes in one write
    always_ff @(posedge clk) begin
        if (avg_we) begin
            for (int c = 0; c < num_ch; c++) begin
                avg_mem[c] <= avg[c*8 +: 8];
            end
        end
        if (red_we) begin
            for (int j = 0; j < num_red; j++) begin
                red_mem[j] <= red[j*8 +: 8];
            end
        end
    end

    // squeezed area only uses the low index bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_byte <= '0;
        end else if (rd_red) begin
            rd_byte <= red_mem[rd_idx[1:0]];
        end else begin
            rd_byte <= avg_mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== design/se_datapath/se_weight_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module se_weight_ram import se_pkg::*; (
    input  wire logic       clk,
    input  wire weight_wr_t weight_wr,
    input  wire waddr_t     rd_addr,
    output word_t           rd_data
);

    // reduce words at 0..15, expand words from expand_base
    word_t mem [wram_depth];

    always_ff @(posedge clk) begin
        if (weight_wr.en) begin
            mem[weight_wr.addr] <= weight_wr.data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/se_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module se_top import se_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire pixel_in_t  pixel_in,
    input  wire weight_wr_t weight_wr,
    output se_result_t      res,
    output logic            res_req,
    input  wire logic       res_ack
);

    se_state_t state;
    logic      frame_done;
    pixel_t    avg;

    // counter handshake
    logic      step;
    logic      clear;
    logic      limit_small;
    chan_idx_t k;
    group_t    g;
    logic      last_k;
    logic      last_g;

    // datapath control
    chan_idx_t fb_rd_idx;
    logic      fb_rd_red;
    logic      fb_red_we;
    waddr_t    wr_rd_addr;
    logic      pe_clear;
    logic      pe_acc_en;

    byte_t     act;
    word_t     weights;
    word_t     pe_result;

    se_sequencer i_se_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_done  (frame_done),
        .k           (k),
        .g           (g),
        .last_k      (last_k),
        .last_g      (last_g),
        .pe_result   (pe_result),
        .res_ack     (res_ack),
        .state       (state),
        .step        (step),
        .clear       (clear),
        .limit_small (limit_small),
        .fb_rd_idx   (fb_rd_idx),
        .fb_rd_red   (fb_rd_red),
        .wr_rd_addr  (wr_rd_addr),
        .pe_clear    (pe_clear),
        .pe_acc_en   (pe_acc_en),
        .fb_red_we   (fb_red_we),
        .res         (res),
        .res_req     (res_req)
    );

    se_step_counter i_se_step_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .step        (step),
        .clear       (clear),
        .limit_small (limit_small),
        .k           (k),
        .g           (g),
        .last_k      (last_k),
        .last_g      (last_g)
    );

    // pixels only count while the sequencer is idle in pooling
    avg_pool_accum i_avg_pool_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .pixel_in   (pixel_in),
        .accept     (state == ST_POOL),
        .avg        (avg),
        .frame_done (frame_done)
    );

    se_weight_ram i_se_weight_ram (
        .clk       (clk),
        .weight_wr (weight_wr),
        .rd_addr   (wr_rd_addr),
        .rd_data   (weights)
    );

    se_feature_buffer i_se_feature_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .avg_we  (frame_done),
        .avg     (avg),
        .red_we  (fb_red_we),
        .red     (pe_result),
        .rd_idx  (fb_rd_idx),
        .rd_red  (fb_rd_red),
        .rd_byte (act)
    );

    pe_array_1x1 i_pe_array_1x1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (pe_clear),
        .acc_en  (pe_acc_en),
        .act     (act),
        .weights (weights),
        .result  (pe_result)
    );

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verif
common/se_pkg.sv
design/se_control/se_step_counter.sv
design/se_control/se_sequencer.sv
design/se_datapath/avg_pool_accum.sv
design/se_datapath/se_weight_ram.sv
design/se_datapath/se_feature_buffer.sv
design/se_datapath/pe_array_1x1.sv
design/se_top.sv
verif/se_tb.sv

// ==== verif/se_ref_model.svh ====
`ifndef SE_REF_MODEL_SVH
`define SE_REF_MODEL_SVH

// whole frame, pixel p at bits p*128 and channel c inside it at c*8
typedef logic [pool_pixels*num_ch*8-1:0] frame_t;

// weight memory image, word a at bits a*32 and lane j inside it at j*8
typedef logic [wram_depth*num_pe*8-1:0] wset_t;

// shift right, clip at one byte
function automatic byte_t quantize(input int unsigned acc);
    int unsigned q;
    q = acc >> quant_shift;
    if (q > 255) begin
        return 8'hff;
    end
    return byte_t'(q);
endfunction

// per-channel sum over the frame, truncated average
function automatic pixel_t pool_average(input frame_t px);
    pixel_t      avg_v;
    int unsigned sum;
    for (int c = 0; c < num_ch; c++) begin
        sum = 0;
        for (int p = 0; p < pool_pixels; p++) begin
            sum += px[(p*num_ch + c)*8 +: 8];
        end
        avg_v[c*8 +: 8] = byte_t'(sum >> pool_shift);
    end
    return avg_v;
endfunction

// 16 to 4 channels, word k holds the weights of input channel k
function automatic word_t reduce_conv(input pixel_t avg_v, input wset_t w);
    word_t       red;
    int unsigned acc;
    for (int j = 0; j < num_red; j++) begin
        acc = 0;
        for (int k = 0; k < num_ch; k++) begin
            acc += avg_v[k*8 +: 8] * w[(k*num_pe + j)*8 +: 8];
        end
        red[j*8 +: 8] = quantize(acc);
    end
    return red;
endfunction

// one output group of four channels from the squeezed values
function automatic word_t expand_conv(input word_t red, input wset_t w, input int g);
    word_t       out_w;
    int unsigned acc;
    for (int j = 0; j < num_pe; j++) begin
        acc = 0;
        for (int k = 0; k < num_red; k++) begin
            acc += red[k*8 +: 8] * w[((expand_base + g*num_red + k)*num_pe + j)*8 +: 8];
        end
        out_w[j*8 +: 8] = quantize(acc);
    end
    return out_w;
endfunction

`endif

// ==== verif/se_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module se_tb import se_pkg::*; ();

    `include "se_ref_model.svh"

    localparam int num_groups   = num_ch / num_pe;
    localparam int num_frames   = 6;
    localparam int frame_cycles = 200;
    localparam int max_cycles   = num_frames * frame_cycles;

    logic       clk;
    logic       rst_n;
    pixel_in_t  pixel_in;
    weight_wr_t weight_wr;
    se_result_t res;
    logic       res_req;
    logic       res_ack;

    int         seed = 32'h6d01_6b26;
    frame_t     frame_px;
    wset_t      wset;
    word_t      exp_word [num_groups];
    string      test_name;
    int         test_errors;
    int         pass_cnt;
    int         fail_cnt;
    int         got_cnt;
    int         cycle_cnt;
    int         ack_delay;
    logic       slow_ack;
    logic       ack_q;
    logic       req_prev;
    se_result_t res_prev;

    se_top i_se_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_in  (pixel_in),
        .weight_wr (weight_wr),
        .res       (res),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_cnt);
        $display("Test FAILED");
        $finish;
    end

    // ack level the DUT saw at the last rising edge
    always @(posedge clk) begin
        ack_q <= res_ack;
    end

    // four-phase responder with a 0 to 3 cycle delay on each ack edge
    always begin
        @(negedge clk);
        if (res_req && !res_ack) begin
            ack_delay = slow_ack ? 3 : ($unsigned($random(seed)) % 4);
            repeat (ack_delay) @(negedge clk);
            res_ack = 1'b1;
        end else if (!res_req && res_ack) begin
            ack_delay = slow_ack ? 3 : ($unsigned($random(seed)) % 4);
            repeat (ack_delay) @(negedge clk);
            res_ack = 1'b0;
        end
    end

    // one new result checked per rising res_req
    always @(negedge clk) begin
        if (rst_n) begin
            if (res_req && !req_prev) begin
                if (ack_q) begin
                    $display("%s: res_req raised again before ack went low", test_name);
                    test_errors++;
                end
                if (got_cnt >= num_groups) begin
                    $display("%s: extra result after the last group", test_name);
                    test_errors++;
                end else begin
                    if (res.group !== group_t'(got_cnt)) begin
                        $display("mismatch %s group number: expected %0d, actual %0d",
                                 test_name, got_cnt, res.group);
                        test_errors++;
                    end
                    if (res.data !== exp_word[got_cnt]) begin
                        $display("mismatch %s group %0d data: expected %h, actual %h",
                                 test_name, got_cnt, exp_word[got_cnt], res.data);
                        test_errors++;
                    end
                end
                got_cnt++;
            end else if (res_req && res !== res_prev) begin
                $display("%s: res changed while res_req waited for ack", test_name);
                test_errors++;
            end else if (!res_req && req_prev && !ack_q) begin
                $display("%s: res_req dropped before ack arrived", test_name);
                test_errors++;
            end
        end
        req_prev = res_req;
        res_prev = res;
    end

    task automatic fill_const(input byte_t pix, input byte_t wt);
        for (int i = 0; i < pool_pixels*num_ch; i++) begin
            frame_px[i*8 +: 8] = pix;
        end
        for (int a = 0; a < wram_depth*num_pe; a++) begin
            wset[a*8 +: 8] = wt;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < pool_pixels*num_ch; i++) begin
            frame_px[i*8 +: 8] = byte_t'($random(seed));
        end
        // small weights keep most outputs below the clip level
        for (int a = 0; a < wram_depth*num_pe; a++) begin
            wset[a*8 +: 8] = byte_t'($random(seed)) &
                             ((a < expand_base*num_pe) ? 8'h0f : 8'h3f);
        end
    endtask

    task automatic compute_expected();
        pixel_t avg_v;
        word_t  red;
        avg_v = pool_average(frame_px);
        red   = reduce_conv(avg_v, wset);
        for (int g = 0; g < num_groups; g++) begin
            exp_word[g] = expand_conv(red, wset, g);
        end
    endtask

    task automatic load_weights();
        for (int a = 0; a < wram_depth; a++) begin
            @(negedge clk);
            weight_wr.en   = 1'b1;
            weight_wr.addr = waddr_t'(a);
            weight_wr.data = wset[a*num_pe*8 +: num_pe*8];
        end
        @(negedge clk);
        weight_wr = '0;
    endtask

    task automatic send_frame();
        for (int p = 0; p < pool_pixels; p++) begin
            @(negedge clk);
            pixel_in.valid = 1'b1;
            pixel_in.data  = frame_px[p*num_ch*8 +: num_ch*8];
        end
        @(negedge clk);
        pixel_in = '0;
    endtask

    task automatic run_frame();
        got_cnt = 0;
        load_weights();
        send_frame();
        // all groups out and the last handshake closed
        while (got_cnt < num_groups || res_req || res_ack) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_cnt++;
            $display("%s: pass", test_name);
        end else begin
            fail_cnt++;
            $display("%s: fail with %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        pixel_in  = '0;
        weight_wr = '0;
        res_ack   = 1'b0;
        slow_ack  = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        got_cnt   = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        @(negedge clk);
        if (res_req !== 1'b0) begin
            $display("mismatch %s res_req: expected 0, actual %b", test_name, res_req);
            test_errors++;
        end
        finish_test();

        start_test("const_unit");
        fill_const(8'd200, 8'd1);
        compute_expected();
        run_frame();
        finish_test();

        start_test("random_frame");
        fill_random();
        compute_expected();
        run_frame();
        finish_test();

        // every sum lands far above 255 after the shift
        start_test("saturation");
        fill_const(8'hff, 8'hff);
        for (int g = 0; g < num_groups; g++) begin
            exp_word[g] = '1;
        end
        run_frame();
        finish_test();

        start_test("back_pressure");
        slow_ack = 1'b1;
        fill_random();
        compute_expected();
        run_frame();
        slow_ack = 1'b0;
        finish_test();

        start_test("two_frames");
        fill_random();
        compute_expected();
        run_frame();
        fill_random();
        compute_expected();
        run_frame();
        finish_test();

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
